//--- bench/execute_tb.sv
/*
 * Execute path testbench
 * Drives LFSR stimulus into the execute path and checks the writeback
 * outputs against a reference model with concurrent assertions
 */
`timescale 1ns/1ns
`default_nettype none

module execute_tb
	import execute_pkg::*;
();
	localparam int NUM_LANES = 4;
	localparam int RANDOM_COUNT = 40;
	localparam int SPECIAL_REPEATS = 4;
	localparam int RECIP_COUNT = 8;
	localparam int SQUASH_REPEATS = 4;
	localparam int TOTAL_CYCLES = 8 + 4 + RANDOM_COUNT + 9 * SPECIAL_REPEATS
		+ 2 * RECIP_COUNT + 7 * 2 * 3 + SQUASH_REPEATS * 8 + 4;
	localparam int TIMEOUT_NS = TOTAL_CYCLES * 8 + 100;

	typedef struct packed
	{
		logic write_en;
		thread_idx_t write_thread;
		logic [NUM_LANES - 1:0] write_mask;
		scalar_t [NUM_LANES - 1:0] write_value;
		logic rollback_en;
		thread_idx_t rollback_thread;
		scalar_t rollback_pc;
	} prediction_t;

	logic clk;
	logic reset;
	logic of_instruction_valid;
	alu_op_t of_alu_op;
	logic of_is_branch;
	branch_type_t of_branch_type;
	scalar_t of_pc;
	scalar_t of_immediate;
	thread_idx_t of_thread_idx;
	scalar_t [NUM_LANES - 1:0] of_operand1;
	scalar_t [NUM_LANES - 1:0] of_operand2;
	logic [NUM_LANES - 1:0] of_mask;
	logic wb_write_en;
	thread_idx_t wb_write_thread;
	logic [NUM_LANES - 1:0] wb_write_mask;
	scalar_t [NUM_LANES - 1:0] wb_write_value;
	logic wb_rollback_en;
	thread_idx_t wb_rollback_thread_idx;
	scalar_t wb_rollback_pc;

	// Predictions of instructions still in the pipeline with the oldest at the front
	prediction_t pred_q[$];
	string name_q[$];
	prediction_t expected;
	string expected_name;
	logic [31:0] lfsr_state = 32'h03b1f688;

	execute_top #(.NUM_LANES(NUM_LANES)) execute_top_inst(.*);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = !clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic next_random_bit();
		logic feedback;

		feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], feedback};
		return feedback;
	endfunction

	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;

		value = '0;
		for (int i = 0; i < count; i++)
			value = {value[30:0], next_random_bit()};
		return value;
	endfunction

	function automatic scalar_t model_lane(input alu_op_t op, input scalar_t a, input scalar_t b,
		input scalar_t [NUM_LANES - 1:0] vec);
		int count;
		int index;
		logic [7:0] exponent;

		count = 0;
		case (op)
			OP_OR: return a | b;
			OP_AND: return a & b;
			OP_XOR: return a ^ b;
			OP_IADD: return a + b;
			OP_ISUB: return a - b;
			OP_COPY: return b;
			OP_UMINUS: return 32'd0 - b;
			OP_LSL: return b > 31 ? 32'd0 : a << b;
			OP_LSR: return b > 31 ? 32'd0 : a >> b;
			OP_ASR: return b > 31 ? {32{a[31]}} : scalar_t'($signed(a) >>> b);
			OP_CLZ:
			begin
				while (count < 32 && !b[31 - count])
					count++;
				return scalar_t'(count);
			end
			OP_CTZ:
			begin
				while (count < 32 && !b[count])
					count++;
				return scalar_t'(count);
			end
			OP_SEXT8: return {{24{b[7]}}, b[7:0]};
			OP_SEXT16: return {{16{b[15]}}, b[15:0]};
			OP_GETLANE, OP_SHUFFLE: return vec[NUM_LANES - 1 - int'(b)];
			OP_RECIP:
			begin
				exponent = b[30:23];
				index = int'(b[22:17]);
				if (exponent == 8'h00)
					return {b[31], 8'hff, 23'd0};
				if (exponent == 8'hff)
					return b[22:0] != 23'd0 ? 32'h7fffffff : {b[31], 31'd0};
				count = index == 0 ? 0 : 8192 / (64 + index) - 64;
				exponent = 8'(253 - int'(exponent) + (index == 0 ? 1 : 0));
				return {b[31], exponent, count[5:0], 17'd0};
			end
			OP_EQUAL: return {31'd0, a == b};
			OP_NEQUAL: return {31'd0, a != b};
			OP_SIGTR: return {31'd0, $signed(a) > $signed(b)};
			OP_SIGTE: return {31'd0, $signed(a) >= $signed(b)};
			OP_SILT: return {31'd0, $signed(a) < $signed(b)};
			OP_SILTE: return {31'd0, $signed(a) <= $signed(b)};
			OP_UIGTR: return {31'd0, a > b};
			OP_UIGTE: return {31'd0, a >= b};
			OP_UILT: return {31'd0, a < b};
			OP_UILTE: return {31'd0, a <= b};
			default: return 32'd0;
		endcase
	endfunction

	// Lane 0 value that makes the branch condition hold or fail
	function automatic scalar_t condition_value(input branch_type_t kind, input logic hold,
		input scalar_t value);
		case (kind)
			BRANCH_ALL: return hold ? value | 32'hffff : value & ~32'h1;
			BRANCH_NOT_ALL: return hold ? value & ~32'h1 : value | 32'hffff;
			BRANCH_ZERO: return hold ? 32'd0 : value | 32'h1;
			BRANCH_NOT_ZERO: return hold ? value | 32'h1 : 32'd0;
			default: return value;
		endcase
	endfunction

	task automatic predict(input string name);
		prediction_t p;
		logic valid;
		logic condition;

		valid = of_instruction_valid;
		// A taken branch two issues back kills this thread
		if (pred_q.size() == 2 && pred_q[0].rollback_en
			&& pred_q[0].rollback_thread == of_thread_idx)
			valid = 1'b0;
		case (of_branch_type)
			BRANCH_ALL: condition = of_operand1[0][15:0] == 16'hffff;
			BRANCH_NOT_ALL: condition = of_operand1[0][15:0] != 16'hffff;
			BRANCH_ZERO: condition = of_operand1[0] == 32'd0;
			BRANCH_NOT_ZERO: condition = of_operand1[0] != 32'd0;
			BRANCH_ALWAYS, BRANCH_CALL_OFFSET, BRANCH_CALL_REGISTER: condition = 1'b1;
			default: condition = 1'b0;
		endcase
		condition = condition && of_is_branch;
		p.write_en = valid && !condition;
		p.write_thread = of_thread_idx;
		p.write_mask = of_mask;
		for (int lane = 0; lane < NUM_LANES; lane++)
			p.write_value[lane] = model_lane(of_alu_op, of_operand1[lane], of_operand2[lane],
				of_operand1);
		p.rollback_en = valid && condition;
		p.rollback_thread = of_thread_idx;
		p.rollback_pc = of_branch_type == BRANCH_CALL_REGISTER ? of_operand1[0]
			: of_pc + 32'd4 + of_immediate;
		pred_q.push_back(p);
		name_q.push_back(name);
	endtask

	// Waits for the next cycle and drives a random non-branch instruction
	task automatic next_instruction();
		@(posedge clk);
		#1;
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			of_operand1[lane] = random_bits(32);
			of_operand2[lane] = random_bits(32);
		end
		of_mask = NUM_LANES'(random_bits(NUM_LANES));
		of_thread_idx = thread_idx_t'(random_bits(2));
		of_pc = random_bits(30) << 2;
		of_immediate = random_bits(32);
		of_instruction_valid = 1'b1;
		of_alu_op = OP_IADD;
		of_is_branch = 1'b0;
		of_branch_type = BRANCH_ALWAYS;
	endtask

	task automatic idle();
		@(posedge clk);
		#1;
		of_instruction_valid = 1'b0;
		of_is_branch = 1'b0;
		predict("idle");
	endtask

	task automatic report_mismatch(input string field, input logic [127:0] expected_value,
		input logic [127:0] actual_value);
		$display("mismatch in %s, test %s: expected %0h, actual %0h", field, expected_name,
			expected_value, actual_value);
		$display("Something failed");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	// Head of the queue lines up with the wb outputs at the next rising edge
	always @(negedge clk)
	begin
		if (!reset && pred_q.size() == 3)
		begin
			expected = pred_q.pop_front();
			expected_name = name_q.pop_front();
		end
	end

	write_en_check: assert property (@(posedge clk) disable iff (reset)
		wb_write_en == expected.write_en)
	else
		report_mismatch("write enable", expected.write_en, $sampled(wb_write_en));

	write_port_check: assert property (@(posedge clk) disable iff (reset)
		expected.write_en |-> {wb_write_thread, wb_write_mask}
			== {expected.write_thread, expected.write_mask})
	else
		report_mismatch("write thread and mask", {expected.write_thread, expected.write_mask},
			$sampled({wb_write_thread, wb_write_mask}));

	write_value_check: assert property (@(posedge clk) disable iff (reset)
		expected.write_en |-> wb_write_value == expected.write_value)
	else
		report_mismatch("write value", expected.write_value, $sampled(wb_write_value));

	rollback_en_check: assert property (@(posedge clk) disable iff (reset)
		wb_rollback_en == expected.rollback_en)
	else
		report_mismatch("rollback enable", expected.rollback_en, $sampled(wb_rollback_en));

	rollback_target_check: assert property (@(posedge clk) disable iff (reset)
		expected.rollback_en |-> {wb_rollback_thread_idx, wb_rollback_pc}
			== {expected.rollback_thread, expected.rollback_pc})
	else
		report_mismatch("rollback thread and pc", {expected.rollback_thread,
			expected.rollback_pc}, $sampled({wb_rollback_thread_idx, wb_rollback_pc}));

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Something failed");
		$fatal(1, "Watchdog expired");
	end

	initial
	begin
		alu_op_t random_ops [17];
		alu_op_t special_ops [9];
		branch_type_t kinds [7];
		thread_idx_t thread;

		reset = 1'b1;
		of_instruction_valid = 1'b0;
		of_alu_op = OP_OR;
		of_is_branch = 1'b0;
		of_branch_type = BRANCH_ALWAYS;
		of_pc = '0;
		of_immediate = '0;
		of_thread_idx = '0;
		of_operand1 = '0;
		of_operand2 = '0;
		of_mask = '0;
		expected = '0;
		expected_name = "reset";
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		// Nothing issued yet, so both enables must stay low
		repeat (4) idle();

		random_ops = '{OP_OR, OP_AND, OP_XOR, OP_IADD, OP_ISUB, OP_COPY, OP_UMINUS, OP_EQUAL,
			OP_NEQUAL, OP_SIGTR, OP_SIGTE, OP_SILT, OP_SILTE, OP_UIGTR, OP_UIGTE, OP_UILT,
			OP_UILTE};
		repeat (RANDOM_COUNT)
		begin
			next_instruction();
			of_alu_op = random_ops[random_bits(5) % 17];
			// Equal operands hit the zero flag of the compares
			if (next_random_bit())
				of_operand2[1] = of_operand1[1];
			predict("random alu");
		end

		special_ops = '{OP_CLZ, OP_CTZ, OP_LSL, OP_LSR, OP_ASR, OP_SEXT8, OP_SEXT16,
			OP_GETLANE, OP_SHUFFLE};
		foreach (special_ops[i])
		begin
			repeat (SPECIAL_REPEATS)
			begin
				next_instruction();
				of_alu_op = special_ops[i];
				of_operand1[0] = '0;
				of_operand1[1][31] = 1'b1;
				of_operand2[0] = '0;
				of_operand2[1] = random_bits(32) >> random_bits(5);
				of_operand2[2] = 32 + random_bits(8);
				// In-range shift amounts in the top lane
				if (of_alu_op == OP_LSL || of_alu_op == OP_LSR || of_alu_op == OP_ASR)
					of_operand2[3] = random_bits(5);
				if (of_alu_op == OP_GETLANE || of_alu_op == OP_SHUFFLE)
				begin
					for (int lane = 0; lane < NUM_LANES; lane++)
						of_operand2[lane] = random_bits(2);
				end
				predict("count, shift, extend and lane select");
			end
		end

		repeat (RECIP_COUNT)
		begin
			// Zero or subnormal, infinity, NaN, then a zero top significand
			next_instruction();
			of_alu_op = OP_RECIP;
			of_operand2[0][30:23] = 8'h00;
			if (next_random_bit())
				of_operand2[0][22:0] = '0;
			of_operand2[1][30:0] = {8'hff, 23'd0};
			of_operand2[2][30:23] = 8'hff;
			of_operand2[2][0] = 1'b1;
			of_operand2[3][30:17] = {8'(1 + random_bits(7)), 6'd0};
			predict("reciprocal special values");
			next_instruction();
			of_alu_op = OP_RECIP;
			for (int lane = 0; lane < NUM_LANES; lane++)
			begin
				if (of_operand2[lane][30:23] == 8'h00 || of_operand2[lane][30:23] == 8'hff)
					of_operand2[lane][30:23] = 8'd1;
			end
			predict("reciprocal normal values");
		end

		kinds = '{BRANCH_ALL, BRANCH_ZERO, BRANCH_NOT_ZERO, BRANCH_ALWAYS, BRANCH_CALL_OFFSET,
			BRANCH_NOT_ALL, BRANCH_CALL_REGISTER};
		foreach (kinds[i])
		begin
			for (int hold = 0; hold < 2; hold++)
			begin
				next_instruction();
				of_is_branch = 1'b1;
				of_branch_type = kinds[i];
				of_operand1[0] = condition_value(kinds[i], hold != 0, of_operand1[0]);
				// Unconditional kinds only fall through when not a branch at all
				if (kinds[i] == BRANCH_ALWAYS || kinds[i] == BRANCH_CALL_OFFSET
					|| kinds[i] == BRANCH_CALL_REGISTER)
					of_is_branch = hold != 0;
				predict("branch");
				idle();
				idle();
			end
		end

		repeat (SQUASH_REPEATS)
		begin
			for (int other = 0; other < 2; other++)
			begin
				next_instruction();
				thread = of_thread_idx;
				of_is_branch = 1'b1;
				predict("squash branch");
				next_instruction();
				of_thread_idx = thread;
				predict("squash shadow slot");
				next_instruction();
				of_alu_op = OP_XOR;
				of_thread_idx = thread + thread_idx_t'(other);
				predict(other != 0 ? "squash other thread" : "squash same thread");
				idle();
			end
		end

		repeat (4) idle();
		$display("Everything OK");
		$finish;
	end
endmodule

`default_nettype wire

//--- files.f
hw/execute_pkg.sv
hw/reciprocal_rom.sv
hw/lane_alu.sv
hw/branch_resolve.sv
hw/single_cycle_execute_stage.sv
hw/writeback_stage.sv
hw/execute_top.sv
bench/execute_tb.sv

//--- hw/branch_resolve.sv
/*
 * Branch resolution
 * Tests the branch condition on lane 0 and forms the target address
 */
`timescale 1ns/1ns
`default_nettype none

module branch_resolve
	import execute_pkg::*;
(
	input wire logic is_branch,
	input wire branch_type_t branch_type,
	input wire scalar_t test_value,
	input wire scalar_t pc,
	input wire scalar_t immediate,
	output logic taken,
	output scalar_t target
);
	logic condition;

	always_comb
	begin
		case (branch_type)
			BRANCH_ALL: condition = test_value[15:0] == 16'hffff;
			BRANCH_NOT_ALL: condition = test_value[15:0] != 16'hffff;
			BRANCH_ZERO: condition = test_value == 32'd0;
			BRANCH_NOT_ZERO: condition = test_value != 32'd0;
			BRANCH_ALWAYS,
			BRANCH_CALL_OFFSET,
			BRANCH_CALL_REGISTER: condition = 1'b1;
			default: condition = 1'b0;
		endcase
	end

	assign taken = is_branch && condition;

	// Register calls jump to the value itself and everything else is pc relative
	assign target = branch_type == BRANCH_CALL_REGISTER ? test_value
		: pc + 32'd4 + immediate;
endmodule

`default_nettype wire

//--- hw/execute_pkg.sv
/*
 * Execute path definitions
 * Shared lane and thread widths, ALU operation codes and branch kinds
 */
`default_nettype none

package execute_pkg;
	typedef logic [31:0] scalar_t;
	typedef logic [1:0] thread_idx_t;
	typedef logic [4:0] alu_op_t;
	typedef logic [2:0] branch_type_t;

	// Logic and arithmetic
	localparam alu_op_t OP_OR = 5'd0;
	localparam alu_op_t OP_AND = 5'd1;
	localparam alu_op_t OP_XOR = 5'd2;
	localparam alu_op_t OP_IADD = 5'd3;
	localparam alu_op_t OP_ISUB = 5'd4;
	localparam alu_op_t OP_COPY = 5'd5;
	localparam alu_op_t OP_UMINUS = 5'd6;
	localparam alu_op_t OP_LSL = 5'd7;
	localparam alu_op_t OP_LSR = 5'd8;
	localparam alu_op_t OP_ASR = 5'd9;
	localparam alu_op_t OP_CLZ = 5'd10;
	localparam alu_op_t OP_CTZ = 5'd11;
	localparam alu_op_t OP_SEXT8 = 5'd12;
	localparam alu_op_t OP_SEXT16 = 5'd13;
	localparam alu_op_t OP_GETLANE = 5'd14;
	localparam alu_op_t OP_SHUFFLE = 5'd15;
	localparam alu_op_t OP_RECIP = 5'd16;

	// Compares that return 0 or 1
	localparam alu_op_t OP_EQUAL = 5'd17;
	localparam alu_op_t OP_NEQUAL = 5'd18;
	localparam alu_op_t OP_SIGTR = 5'd19;
	localparam alu_op_t OP_SIGTE = 5'd20;
	localparam alu_op_t OP_SILT = 5'd21;
	localparam alu_op_t OP_SILTE = 5'd22;
	localparam alu_op_t OP_UIGTR = 5'd23;
	localparam alu_op_t OP_UIGTE = 5'd24;
	localparam alu_op_t OP_UILT = 5'd25;
	localparam alu_op_t OP_UILTE = 5'd26;

	localparam branch_type_t BRANCH_ALL = 3'd0;
	localparam branch_type_t BRANCH_ZERO = 3'd1;
	localparam branch_type_t BRANCH_NOT_ZERO = 3'd2;
	localparam branch_type_t BRANCH_ALWAYS = 3'd3;
	localparam branch_type_t BRANCH_CALL_OFFSET = 3'd4;
	localparam branch_type_t BRANCH_NOT_ALL = 3'd5;
	localparam branch_type_t BRANCH_CALL_REGISTER = 3'd6;
endpackage

`default_nettype wire

//--- hw/execute_top.sv
/*
 * Integer execute path
 * Execute stage followed by writeback, with rollback fed back
 */
`timescale 1ns/1ns
`default_nettype none

module execute_top
	import execute_pkg::*;
#(
	parameter int NUM_LANES = 4
)
(
	input wire logic clk,
	input wire logic reset,

	input wire logic of_instruction_valid,
	input wire alu_op_t of_alu_op,
	input wire logic of_is_branch,
	input wire branch_type_t of_branch_type,
	input wire scalar_t of_pc,
	input wire scalar_t of_immediate,
	input wire thread_idx_t of_thread_idx,
	input wire scalar_t [NUM_LANES - 1:0] of_operand1,
	input wire scalar_t [NUM_LANES - 1:0] of_operand2,
	input wire logic [NUM_LANES - 1:0] of_mask,

	output logic wb_write_en,
	output thread_idx_t wb_write_thread,
	output logic [NUM_LANES - 1:0] wb_write_mask,
	output scalar_t [NUM_LANES - 1:0] wb_write_value,
	output logic wb_rollback_en,
	output thread_idx_t wb_rollback_thread_idx,
	output scalar_t wb_rollback_pc
);
	logic sx_instruction_valid;
	scalar_t [NUM_LANES - 1:0] sx_result;
	logic [NUM_LANES - 1:0] sx_mask;
	thread_idx_t sx_thread_idx;
	logic sx_rollback_en;
	scalar_t sx_rollback_pc;

	single_cycle_execute_stage #(.NUM_LANES(NUM_LANES)) execute_inst(.*);

	writeback_stage #(.NUM_LANES(NUM_LANES)) writeback_inst(.*);
endmodule

`default_nettype wire

//--- hw/lane_alu.sv
/*
 * Single lane integer ALU
 * Logic, add/subtract, compares, bit counts, shifts, sign extension,
 * lane select and reciprocal estimate, all combinational
 */
`timescale 1ns/1ns
`default_nettype none

module lane_alu
	import execute_pkg::*;
#(
	parameter int NUM_LANES = 4
)
(
	input wire alu_op_t alu_op,
	input wire scalar_t operand1,
	input wire scalar_t operand2,
	input wire scalar_t [NUM_LANES - 1:0] operand1_vector,
	output scalar_t result
);
	localparam int LANE_BITS = $clog2(NUM_LANES);

	scalar_t difference;
	logic borrow;
	logic negative;
	logic overflow;
	logic zero;
	logic signed_gtr;
	logic [5:0] lz;
	logic [5:0] tz;
	logic shift_in_sign;
	logic shift_in_range;
	logic [63:0] rshift_wide;
	scalar_t lane_index;
	logic fp_sign;
	logic [7:0] fp_exponent;
	logic [22:0] fp_significand;
	logic [5:0] recip_estimate;
	logic [7:0] recip_exponent;
	scalar_t reciprocal;

	// One subtract serves every compare
	assign {borrow, difference} = {1'b0, operand1} - {1'b0, operand2};
	assign negative = difference[31];
	assign overflow = operand2[31] == negative && operand1[31] != operand2[31];
	assign zero = difference == 32'd0;
	assign signed_gtr = overflow == negative;

	// Highest set bit wins
	always_comb
	begin
		lz = 6'd32;
		for (int i = 0; i < 32; i++)
		begin
			if (operand2[i])
				lz = 6'(31 - i);
		end
	end

	// Lowest set bit wins
	always_comb
	begin
		tz = 6'd32;
		for (int i = 31; i >= 0; i--)
		begin
			if (operand2[i])
				tz = 6'(i);
		end
	end

	assign shift_in_sign = alu_op == OP_ASR ? operand1[31] : 1'b0;
	assign shift_in_range = operand2[31:5] == 27'd0;
	assign rshift_wide = {{32{shift_in_sign}}, operand1} >> operand2[4:0];

	// Lane 0 of the source sits in the top word from the lane's point of view
	assign lane_index = scalar_t'(NUM_LANES - 1) - operand2;

	assign fp_sign = operand2[31];
	assign fp_exponent = operand2[30:23];
	assign fp_significand = operand2[22:0];
	assign recip_exponent = 8'd253 - fp_exponent + {7'd0, fp_significand[22:17] == 6'd0};

	reciprocal_rom rom_inst(
		.significand(fp_significand[22:17]),
		.estimate(recip_estimate)
	);

	always_comb
	begin
		if (fp_exponent == 8'd0)
			reciprocal = {fp_sign, 8'hff, 23'd0};
		else if (fp_exponent == 8'hff)
			reciprocal = fp_significand != 23'd0 ? 32'h7fffffff : {fp_sign, 31'd0};
		else
			reciprocal = {fp_sign, recip_exponent, recip_estimate, 17'd0};
	end

	always_comb
	begin
		case (alu_op)
			OP_OR: result = operand1 | operand2;
			OP_AND: result = operand1 & operand2;
			OP_XOR: result = operand1 ^ operand2;
			OP_IADD: result = operand1 + operand2;
			OP_ISUB: result = difference;
			OP_COPY: result = operand2;
			OP_UMINUS: result = -operand2;
			OP_LSL: result = shift_in_range ? operand1 << operand2[4:0] : 32'd0;
			OP_LSR,
			OP_ASR: result = shift_in_range ? rshift_wide[31:0] : {32{shift_in_sign}};
			OP_CLZ: result = {26'd0, lz};
			OP_CTZ: result = {26'd0, tz};
			OP_SEXT8: result = {{24{operand2[7]}}, operand2[7:0]};
			OP_SEXT16: result = {{16{operand2[15]}}, operand2[15:0]};
			OP_GETLANE,
			OP_SHUFFLE: result = operand1_vector[lane_index[LANE_BITS - 1:0]];
			OP_RECIP: result = reciprocal;
			OP_EQUAL: result = {31'd0, zero};
			OP_NEQUAL: result = {31'd0, !zero};
			OP_SIGTR: result = {31'd0, signed_gtr && !zero};
			OP_SIGTE: result = {31'd0, signed_gtr || zero};
			OP_SILT: result = {31'd0, !signed_gtr && !zero};
			OP_SILTE: result = {31'd0, !signed_gtr || zero};
			OP_UIGTR: result = {31'd0, !borrow && !zero};
			OP_UIGTE: result = {31'd0, !borrow || zero};
			OP_UILT: result = {31'd0, borrow && !zero};
			OP_UILTE: result = {31'd0, borrow || zero};
			default: result = 32'd0;
		endcase
	end

	clz_in_range: assert property (@(lz) lz <= 6'd32);
endmodule

`default_nettype wire

//--- hw/reciprocal_rom.sv
/*
 * Reciprocal estimate table
 * Maps the top six significand bits to six bits of 1/x significand
 */
`timescale 1ns/1ns
`default_nettype none

module reciprocal_rom
(
	input wire logic [5:0] significand,
	output logic [5:0] estimate
);
	logic [5:0] rom_table [64];

	// Entry 0 would be 64, which wraps to 0 in six bits
	for (genvar i = 0; i < 64; i++)
	begin : table_gen
		localparam int ENTRY = (i == 0) ? 0 : 8192 / (64 + i) - 64;

		assign rom_table[i] = 6'(ENTRY);
	end

	assign estimate = rom_table[significand];
endmodule

`default_nettype wire

//--- hw/single_cycle_execute_stage.sv
/*
 * Single cycle execute stage
 * Runs one ALU per lane, resolves branches, drops instructions of a
 * thread being rolled back and registers the results for writeback
 */
`timescale 1ns/1ns
`default_nettype none

module single_cycle_execute_stage
	import execute_pkg::*;
#(
	parameter int NUM_LANES = 4
)
(
	input wire logic clk,
	input wire logic reset,

	// From operand fetch
	input wire logic of_instruction_valid,
	input wire alu_op_t of_alu_op,
	input wire logic of_is_branch,
	input wire branch_type_t of_branch_type,
	input wire scalar_t of_pc,
	input wire scalar_t of_immediate,
	input wire thread_idx_t of_thread_idx,
	input wire scalar_t [NUM_LANES - 1:0] of_operand1,
	input wire scalar_t [NUM_LANES - 1:0] of_operand2,
	input wire logic [NUM_LANES - 1:0] of_mask,

	// Rollback from writeback
	input wire logic wb_rollback_en,
	input wire thread_idx_t wb_rollback_thread_idx,

	// To writeback
	output logic sx_instruction_valid,
	output scalar_t [NUM_LANES - 1:0] sx_result,
	output logic [NUM_LANES - 1:0] sx_mask,
	output thread_idx_t sx_thread_idx,
	output logic sx_rollback_en,
	output scalar_t sx_rollback_pc
);
	scalar_t [NUM_LANES - 1:0] vector_result;
	logic branch_taken;
	scalar_t branch_target;
	logic squash;
	logic issue;

	for (genvar lane = 0; lane < NUM_LANES; lane++)
	begin : lane_gen
		lane_alu #(.NUM_LANES(NUM_LANES)) alu_inst(
			.alu_op(of_alu_op),
			.operand1(of_operand1[lane]),
			.operand2(of_operand2[lane]),
			.operand1_vector(of_operand1),
			.result(vector_result[lane])
		);
	end

	branch_resolve branch_inst(
		.is_branch(of_is_branch),
		.branch_type(of_branch_type),
		.test_value(of_operand1[0]),
		.pc(of_pc),
		.immediate(of_immediate),
		.taken(branch_taken),
		.target(branch_target)
	);

	// A rollback this cycle kills anything from the same thread
	assign squash = wb_rollback_en && wb_rollback_thread_idx == of_thread_idx;
	assign issue = of_instruction_valid && !squash;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sx_instruction_valid <= 1'b0;
			sx_rollback_en <= 1'b0;
			sx_result <= '0;
			sx_mask <= '0;
			sx_thread_idx <= '0;
			sx_rollback_pc <= '0;
		end
		else
		begin
			sx_instruction_valid <= issue;
			sx_rollback_en <= issue && branch_taken;
			sx_result <= vector_result;
			sx_mask <= of_mask;
			sx_thread_idx <= of_thread_idx;
			sx_rollback_pc <= branch_target;
		end
	end

	rollback_needs_valid: assert property (@(posedge clk) disable iff (reset)
		sx_rollback_en |-> sx_instruction_valid);
endmodule

`default_nettype wire

//--- hw/writeback_stage.sv
/*
 * Writeback stage
 * Turns execute results into masked register writes and sends
 * taken branches back as rollbacks
 */
`timescale 1ns/1ns
`default_nettype none

module writeback_stage
	import execute_pkg::*;
#(
	parameter int NUM_LANES = 4
)
(
	input wire logic clk,
	input wire logic reset,

	// From execute
	input wire logic sx_instruction_valid,
	input wire scalar_t [NUM_LANES - 1:0] sx_result,
	input wire logic [NUM_LANES - 1:0] sx_mask,
	input wire thread_idx_t sx_thread_idx,
	input wire logic sx_rollback_en,
	input wire scalar_t sx_rollback_pc,

	// Register file write port
	output logic wb_write_en,
	output thread_idx_t wb_write_thread,
	output logic [NUM_LANES - 1:0] wb_write_mask,
	output scalar_t [NUM_LANES - 1:0] wb_write_value,

	// Rollback
	output logic wb_rollback_en,
	output thread_idx_t wb_rollback_thread_idx,
	output scalar_t wb_rollback_pc
);
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_write_en <= 1'b0;
			wb_rollback_en <= 1'b0;
			wb_write_thread <= '0;
			wb_write_mask <= '0;
			wb_write_value <= '0;
			wb_rollback_thread_idx <= '0;
			wb_rollback_pc <= '0;
		end
		else
		begin
			// Taken branches only redirect and have no result
			wb_write_en <= sx_instruction_valid && !sx_rollback_en;
			wb_rollback_en <= sx_rollback_en;
			wb_write_thread <= sx_thread_idx;
			wb_write_mask <= sx_mask;
			wb_write_value <= sx_result;
			wb_rollback_thread_idx <= sx_thread_idx;
			wb_rollback_pc <= sx_rollback_pc;
		end
	end

	write_or_rollback: assert property (@(posedge clk) disable iff (reset)
		!(wb_write_en && wb_rollback_en));
endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the execute path testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module execute_tb -o sim \
	&& ./obj_dir/sim | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
